// ==== Bender.yml ====
package:
  name: cache_tq

sources:
  - include_dirs:
      - design
    files:
      - design/cache_tq_pkg.sv
      - design/tq_req_decode.sv
      - design/tq_entry_array.sv
      - design/tq_lookup_arb.sv
      - design/cache_tq.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/cache_tq_tb.sv

// ==== design/cache_tq.sv ====
// cache transaction queue top
// core requests, pipe lookups and far-memory fills
`timescale 1ns/1ps
`include "cache_tq_macros.svh"

module cache_tq
    import cache_tq_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // core
    input  logic                      req_valid,
    input  t_core_op                  req_opcode,
    input  logic [`TQ_ADDR_W-1:0]     req_address,
    input  t_word                     req_data,
    input  t_reg_id                   req_reg_id,
    output logic                      stall,
    output logic                      rsp_valid,
    output t_word                     rsp_data,
    output t_reg_id                   rsp_reg_id,
    // pipe
    output logic                      lu_valid,
    output t_lu_op                    lu_op,
    output logic [`TQ_ADDR_W-1:0]     lu_address,
    output t_word                     lu_data,
    output t_cl                       lu_cl_data,
    output t_tq_id                    lu_tq_id,
    output logic                      lu_mb_hit_cancel,
    input  logic                      lu_rsp_valid,
    input  t_lu_op                    lu_rsp_op,
    input  t_lu_result                lu_rsp_result,
    input  logic [`TQ_ADDR_W-1:0]     lu_rsp_address,
    input  t_cl                       lu_rsp_cl_data,
    input  t_tq_id                    lu_rsp_tq_id,
    // far memory
    input  logic                      fm_rsp_valid,
    input  t_tq_id                    fm_rsp_tq_id,
    input  t_cl                       fm_rsp_data
);

    logic         [`TQ_NUM_ENTRY-1:0] alloc_onehot;
    logic         [`TQ_NUM_ENTRY-1:0] rd_merge_onehot;
    logic         [`TQ_NUM_ENTRY-1:0] wr_merge_onehot;
    logic         [`TQ_NUM_ENTRY-1:0] fill_issue_onehot;
    logic                             any_merge;
    t_tq_id                           req_tq_id;
    t_tq_state    [`TQ_NUM_ENTRY-1:0] entry_state;
    t_cl_address  [`TQ_NUM_ENTRY-1:0] entry_cl_address;
    logic         [`TQ_NUM_ENTRY-1:0] entry_rd_ind;
    t_word_offset [`TQ_NUM_ENTRY-1:0] entry_word_offset;
    t_reg_id      [`TQ_NUM_ENTRY-1:0] entry_reg_id;
    t_cl          [`TQ_NUM_ENTRY-1:0] entry_mb_data;

    tq_req_decode i_tq_req_decode (
        .rst_n, .req_valid, .req_opcode, .req_address,
        .entry_state, .entry_cl_address, .entry_rd_ind,
        .stall, .alloc_onehot, .rd_merge_onehot, .wr_merge_onehot,
        .any_merge, .req_tq_id
    );

    tq_entry_array i_tq_entry_array (
        .clk, .rst_n, .req_opcode, .req_address, .req_data, .req_reg_id,
        .alloc_onehot, .rd_merge_onehot, .wr_merge_onehot,
        .lu_rsp_valid, .lu_rsp_result, .lu_rsp_tq_id,
        .fm_rsp_valid, .fm_rsp_tq_id, .fm_rsp_data, .fill_issue_onehot,
        .entry_state, .entry_cl_address, .entry_rd_ind,
        .entry_word_offset, .entry_reg_id, .entry_mb_data
    );

    tq_lookup_arb i_tq_lookup_arb (
        .req_valid, .req_opcode, .req_address, .req_data, .stall,
        .any_merge, .req_tq_id,
        .entry_state, .entry_cl_address, .entry_word_offset, .entry_reg_id,
        .entry_rd_ind, .entry_mb_data,
        .lu_rsp_valid, .lu_rsp_op, .lu_rsp_result, .lu_rsp_tq_id,
        .lu_rsp_address, .lu_rsp_cl_data,
        .lu_valid, .lu_op, .lu_address, .lu_data, .lu_cl_data, .lu_tq_id,
        .lu_mb_hit_cancel, .fill_issue_onehot,
        .rsp_valid, .rsp_data, .rsp_reg_id
    );

endmodule

// ==== design/cache_tq_macros.svh ====
// cache transaction queue
// sizes and address field positions
`ifndef CACHE_TQ_MACROS_SVH
`define CACHE_TQ_MACROS_SVH

// queue depth
`define TQ_NUM_ENTRY 4

// data sizes
`define TQ_WORD_W      32
`define TQ_WORDS_IN_CL 4

// byte address and its fields
`define TQ_ADDR_W          20
`define TQ_LSB_WORD_OFFSET 2
`define TQ_MSB_WORD_OFFSET 3
`define TQ_LSB_CL_ADDR     4  // line address up to TQ_ADDR_W-1

// destination register of a read
`define TQ_REG_ID_W 5

`endif

// ==== design/cache_tq_pkg.sv ====
// cache transaction queue types
// opcodes, lookup results, entry states and field types
`include "cache_tq_macros.svh"

package cache_tq_pkg;

    typedef enum logic {
        RD_OP,
        WR_OP
    } t_core_op;

    typedef enum logic [1:0] {
        NO_LU,
        RD_LU,
        WR_LU,
        FILL_LU
    } t_lu_op;

    typedef enum logic [1:0] {
        HIT,
        MISS,
        FILL
    } t_lu_result;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LU_CORE,       // core lookup in the pipe
        S_MB_WAIT_FILL,  // waiting for far memory
        S_MB_FILL_READY, // merged line ready for fill
        S_FILL_LU        // fill lookup in the pipe
    } t_tq_state;

    typedef logic [`TQ_WORD_W-1:0]                    t_word;
    typedef logic [`TQ_WORDS_IN_CL*`TQ_WORD_W-1:0]    t_cl;
    typedef logic [`TQ_ADDR_W-`TQ_LSB_CL_ADDR-1:0]    t_cl_address;
    typedef logic [`TQ_MSB_WORD_OFFSET-`TQ_LSB_WORD_OFFSET:0] t_word_offset;
    typedef logic [$clog2(`TQ_NUM_ENTRY)-1:0]         t_tq_id;
    typedef logic [`TQ_REG_ID_W-1:0]                  t_reg_id;
    typedef logic [`TQ_WORDS_IN_CL-1:0]               t_word_mask;

endpackage

// ==== design/tq_entry_array.sv ====
// transaction queue entries
// per-entry FSM, line address, read indication and merge buffer
`timescale 1ns/1ps
`include "cache_tq_macros.svh"

module tq_entry_array
    import cache_tq_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  t_core_op                            req_opcode,
    input  logic [`TQ_ADDR_W-1:0]               req_address,
    input  t_word                               req_data,
    input  t_reg_id                             req_reg_id,
    input  logic         [`TQ_NUM_ENTRY-1:0]    alloc_onehot,
    input  logic         [`TQ_NUM_ENTRY-1:0]    rd_merge_onehot,
    input  logic         [`TQ_NUM_ENTRY-1:0]    wr_merge_onehot,
    input  logic                                lu_rsp_valid,
    input  t_lu_result                          lu_rsp_result,
    input  t_tq_id                              lu_rsp_tq_id,
    input  logic                                fm_rsp_valid,
    input  t_tq_id                              fm_rsp_tq_id,
    input  t_cl                                 fm_rsp_data,
    input  logic         [`TQ_NUM_ENTRY-1:0]    fill_issue_onehot,
    output t_tq_state    [`TQ_NUM_ENTRY-1:0]    entry_state,
    output t_cl_address  [`TQ_NUM_ENTRY-1:0]    entry_cl_address,
    output logic         [`TQ_NUM_ENTRY-1:0]    entry_rd_ind,
    output t_word_offset [`TQ_NUM_ENTRY-1:0]    entry_word_offset,
    output t_reg_id      [`TQ_NUM_ENTRY-1:0]    entry_reg_id,
    output t_cl          [`TQ_NUM_ENTRY-1:0]    entry_mb_data
);

    t_word_mask   [`TQ_NUM_ENTRY-1:0] mb_mask; // words written by the core
    t_tq_state    [`TQ_NUM_ENTRY-1:0] nxt_state;
    logic         [`TQ_NUM_ENTRY-1:0] nxt_rd_ind;
    t_cl_address  [`TQ_NUM_ENTRY-1:0] nxt_cl_address;
    t_word_offset [`TQ_NUM_ENTRY-1:0] nxt_word_offset;
    t_reg_id      [`TQ_NUM_ENTRY-1:0] nxt_reg_id;
    t_cl          [`TQ_NUM_ENTRY-1:0] nxt_mb_data;
    t_word_mask   [`TQ_NUM_ENTRY-1:0] nxt_mb_mask;

    t_cl_address  req_cl;
    t_word_offset req_off;

    assign req_cl  = req_address[`TQ_ADDR_W-1:`TQ_LSB_CL_ADDR];
    assign req_off = req_address[`TQ_MSB_WORD_OFFSET:`TQ_LSB_WORD_OFFSET];

    // --------------------------------------------------
    // next state per entry
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
            nxt_state[i]       = entry_state[i];
            nxt_rd_ind[i]      = entry_rd_ind[i];
            nxt_cl_address[i]  = entry_cl_address[i];
            nxt_word_offset[i] = entry_word_offset[i];
            nxt_reg_id[i]      = entry_reg_id[i];
            nxt_mb_data[i]     = entry_mb_data[i];
            nxt_mb_mask[i]     = mb_mask[i];

            case (entry_state[i])
                S_IDLE: begin
                    if (alloc_onehot[i]) begin
                        nxt_state[i]       = S_LU_CORE;
                        nxt_rd_ind[i]      = (req_opcode == RD_OP);
                        nxt_cl_address[i]  = req_cl;
                        nxt_word_offset[i] = req_off;
                        nxt_reg_id[i]      = req_reg_id;
                        nxt_mb_mask[i]     = '0;
                        if (req_opcode == WR_OP) begin
                            nxt_mb_data[i][req_off*`TQ_WORD_W +: `TQ_WORD_W] = req_data;
                            nxt_mb_mask[i][req_off] = 1'b1;
                        end
                    end
                end
                S_LU_CORE: begin
                    if (lu_rsp_valid && (lu_rsp_tq_id == t_tq_id'(i))) begin
                        if (lu_rsp_result == HIT) begin
                            nxt_state[i] = S_IDLE;
                        end else if (lu_rsp_result == MISS) begin
                            nxt_state[i] = S_MB_WAIT_FILL;
                        end
                    end
                end
                S_MB_WAIT_FILL: begin
                    if (fm_rsp_valid && (fm_rsp_tq_id == t_tq_id'(i))) begin
                        nxt_state[i] = S_MB_FILL_READY;
                        for (int w = 0; w < `TQ_WORDS_IN_CL; w++) begin
                            if (!mb_mask[i][w]) begin // keep core-written words
                                nxt_mb_data[i][w*`TQ_WORD_W +: `TQ_WORD_W] =
                                    fm_rsp_data[w*`TQ_WORD_W +: `TQ_WORD_W];
                            end
                        end
                    end
                end
                S_MB_FILL_READY: begin
                    if (fill_issue_onehot[i]) begin
                        nxt_state[i] = S_FILL_LU;
                    end
                end
                S_FILL_LU: begin
                    if (lu_rsp_valid && (lu_rsp_tq_id == t_tq_id'(i)) &&
                        (lu_rsp_result == FILL)) begin
                        nxt_state[i] = S_IDLE;
                    end
                end
                default: nxt_state[i] = S_IDLE;
            endcase

            // read after write, response goes to the later read
            if (rd_merge_onehot[i]) begin
                nxt_rd_ind[i]      = 1'b1;
                nxt_word_offset[i] = req_off;
                nxt_reg_id[i]      = req_reg_id;
            end
            // write after write, applied after the fill merge so it wins
            if (wr_merge_onehot[i]) begin
                nxt_mb_data[i][req_off*`TQ_WORD_W +: `TQ_WORD_W] = req_data;
                nxt_mb_mask[i][req_off] = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // entry registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TQ_NUM_ENTRY; i++) begin
                entry_state[i] <= S_IDLE;
            end
            entry_rd_ind <= '0;
        end else begin
            entry_state  <= nxt_state;
            entry_rd_ind <= nxt_rd_ind;
        end
    end

    always_ff @(posedge clk) begin
        entry_cl_address  <= nxt_cl_address;
        entry_word_offset <= nxt_word_offset;
        entry_reg_id      <= nxt_reg_id;
        entry_mb_data     <= nxt_mb_data;
        mb_mask           <= nxt_mb_mask;
    end

endmodule

// ==== design/tq_lookup_arb.sv ====
// transaction queue output side
// pipe lookup mux (core over fill) and core read response
`timescale 1ns/1ps
`include "cache_tq_macros.svh"

module tq_lookup_arb
    import cache_tq_pkg::*;
(
    input  logic                                req_valid,
    input  t_core_op                            req_opcode,
    input  logic [`TQ_ADDR_W-1:0]               req_address,
    input  t_word                               req_data,
    input  logic                                stall,
    input  logic                                any_merge,
    input  t_tq_id                              req_tq_id,
    input  t_tq_state    [`TQ_NUM_ENTRY-1:0]    entry_state,
    input  t_cl_address  [`TQ_NUM_ENTRY-1:0]    entry_cl_address,
    input  t_word_offset [`TQ_NUM_ENTRY-1:0]    entry_word_offset,
    input  t_reg_id      [`TQ_NUM_ENTRY-1:0]    entry_reg_id,
    input  logic         [`TQ_NUM_ENTRY-1:0]    entry_rd_ind,
    input  t_cl          [`TQ_NUM_ENTRY-1:0]    entry_mb_data,
    input  logic                                lu_rsp_valid,
    input  t_lu_op                              lu_rsp_op,
    input  t_lu_result                          lu_rsp_result,
    input  t_tq_id                              lu_rsp_tq_id,
    input  logic [`TQ_ADDR_W-1:0]               lu_rsp_address,
    input  t_cl                                 lu_rsp_cl_data,
    output logic                                lu_valid,
    output t_lu_op                              lu_op,
    output logic [`TQ_ADDR_W-1:0]               lu_address,
    output t_word                               lu_data,
    output t_cl                                 lu_cl_data,
    output t_tq_id                              lu_tq_id,
    output logic                                lu_mb_hit_cancel,
    output logic         [`TQ_NUM_ENTRY-1:0]    fill_issue_onehot,
    output logic                                rsp_valid,
    output t_word                               rsp_data,
    output t_reg_id                             rsp_reg_id
);

    logic   core_lu;
    logic   fill_found;
    t_tq_id fill_id;
    logic   rd_hit;
    logic   fill_rd;

    assign core_lu = req_valid && !stall; // only accepted requests reach the pipe

    // lowest entry with a merged line ready
    always_comb begin
        fill_found = 1'b0;
        fill_id    = '0;
        for (int i = `TQ_NUM_ENTRY-1; i >= 0; i--) begin
            if (entry_state[i] == S_MB_FILL_READY) begin
                fill_found = 1'b1;
                fill_id    = t_tq_id'(i);
            end
        end
    end

    // --------------------------------------------------
    // pipe lookup mux
    // --------------------------------------------------
    always_comb begin
        lu_valid          = 1'b0;
        lu_op             = NO_LU;
        lu_address        = '0;
        lu_data           = '0;
        lu_cl_data        = '0;
        lu_tq_id          = '0;
        lu_mb_hit_cancel  = 1'b0;
        fill_issue_onehot = '0;
        if (core_lu) begin
            lu_valid         = 1'b1;
            lu_op            = (req_opcode == WR_OP) ? WR_LU : RD_LU;
            lu_address       = req_address;
            lu_data          = req_data;
            lu_tq_id         = req_tq_id;
            lu_mb_hit_cancel = any_merge; // merged into the buffer, no pipe answer
        end else if (fill_found) begin
            lu_valid   = 1'b1;
            lu_op      = FILL_LU;
            lu_address = {entry_cl_address[fill_id], entry_word_offset[fill_id],
                          {`TQ_LSB_WORD_OFFSET{1'b0}}};
            lu_cl_data = entry_mb_data[fill_id];
            lu_tq_id   = fill_id;
            fill_issue_onehot[fill_id] = 1'b1;
        end
    end

    // --------------------------------------------------
    // core read response
    // --------------------------------------------------
    assign rd_hit  = lu_rsp_valid && (lu_rsp_op == RD_LU) && (lu_rsp_result == HIT);
    assign fill_rd = lu_rsp_valid && (lu_rsp_op == FILL_LU) && (lu_rsp_result == FILL) &&
                     entry_rd_ind[lu_rsp_tq_id];

    assign rsp_valid  = rd_hit || fill_rd;
    assign rsp_data   = lu_rsp_cl_data[entry_word_offset[lu_rsp_tq_id]*`TQ_WORD_W +: `TQ_WORD_W];
    assign rsp_reg_id = entry_reg_id[lu_rsp_tq_id];

endmodule

// ==== design/tq_req_decode.sv ====
// transaction queue input side
// matches core requests to open entries, picks a free entry, drives stall
`timescale 1ns/1ps
`include "cache_tq_macros.svh"

module tq_req_decode
    import cache_tq_pkg::*;
(
    input  logic                                rst_n,
    input  logic                                req_valid,
    input  t_core_op                            req_opcode,
    input  logic [`TQ_ADDR_W-1:0]               req_address,
    input  t_tq_state   [`TQ_NUM_ENTRY-1:0]     entry_state,
    input  t_cl_address [`TQ_NUM_ENTRY-1:0]     entry_cl_address,
    input  logic        [`TQ_NUM_ENTRY-1:0]     entry_rd_ind,
    output logic                                stall,
    output logic        [`TQ_NUM_ENTRY-1:0]     alloc_onehot,
    output logic        [`TQ_NUM_ENTRY-1:0]     rd_merge_onehot,
    output logic        [`TQ_NUM_ENTRY-1:0]     wr_merge_onehot,
    output logic                                any_merge,
    output t_tq_id                              req_tq_id
);

    logic [`TQ_NUM_ENTRY-1:0] idle;
    logic [`TQ_NUM_ENTRY-1:0] locked;
    logic [`TQ_NUM_ENTRY-1:0] mergeable;
    logic [`TQ_NUM_ENTRY-1:0] first_free;
    logic                     accept;
    t_tq_id                   free_id;
    t_tq_id                   merge_id;
    t_cl_address              req_cl;

    assign req_cl = req_address[`TQ_ADDR_W-1:`TQ_LSB_CL_ADDR];

    // at most one open entry per line, so mergeable is onehot
    always_comb begin
        first_free = '0;
        free_id    = '0;
        merge_id   = '0;
        for (int i = `TQ_NUM_ENTRY-1; i >= 0; i--) begin
            idle[i]      = (entry_state[i] == S_IDLE);
            locked[i]    = !idle[i] && (entry_cl_address[i] == req_cl) &&
                           ((entry_state[i] == S_LU_CORE) || (entry_state[i] == S_FILL_LU) ||
                            entry_rd_ind[i]); // pending read keeps its word stable
            mergeable[i] = !idle[i] && (entry_cl_address[i] == req_cl) && !entry_rd_ind[i] &&
                           ((entry_state[i] == S_MB_WAIT_FILL) ||
                            (entry_state[i] == S_MB_FILL_READY));
            if (idle[i]) begin
                first_free    = '0;
                first_free[i] = 1'b1; // last hit in a downward loop is the lowest
                free_id       = t_tq_id'(i);
            end
            if (mergeable[i]) begin
                merge_id = t_tq_id'(i);
            end
        end
    end

    assign stall     = !(|idle) || (req_valid && |locked);
    assign accept    = req_valid && !stall && rst_n;
    assign any_merge = req_valid && |mergeable;
    assign req_tq_id = any_merge ? merge_id : free_id;

    assign alloc_onehot    = (accept && !any_merge) ? first_free : '0;
    assign rd_merge_onehot = (accept && (req_opcode == RD_OP)) ? mergeable : '0;
    assign wr_merge_onehot = (accept && (req_opcode == WR_OP)) ? mergeable : '0;

endmodule

// ==== tb.f ====
+incdir+design
+incdir+verif
design/cache_tq_pkg.sv
design/tq_req_decode.sv
design/tq_entry_array.sv
design/tq_lookup_arb.sv
design/cache_tq.sv
verif/cache_tq_tb.sv

// ==== verif/cache_tq_tb_tasks.svh ====
// testbench helpers for the cache transaction queue
// value check, far-memory pattern, request driver and read scoreboard
`ifndef CACHE_TQ_TB_TASKS_SVH
`define CACHE_TQ_TB_TASKS_SVH

task automatic check_val(input string name, input t_cl exp, input t_cl act);
    if (exp !== act) begin
        $display("error: %s expected %0h actual %0h", name, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "check %s failed", name);
    end
endtask

// far-memory contents before any fill, built from the word address
function automatic t_cl fm_line(input t_cl_address cl);
    t_cl line;
    for (int w = 0; w < `TQ_WORDS_IN_CL; w++) begin
        line[w*`TQ_WORD_W +: `TQ_WORD_W] = {14'h2b5, cl, w[1:0]} ^ 32'h0f0f_5a5a;
    end
    return line;
endfunction

function automatic logic queue_drained();
    return !cap.v && !st0.v && !st1.v && !(|fm_pend) && !(|line_open);
endfunction

// hold the request until it is taken, then log it in the golden memory
task automatic send_req(input t_core_op op, input int idx, input int off, input t_word data,
                        output logic cancel);
    logic accepted;
    accepted    = 1'b0;
    cancel      = 1'b0;
    req_valid   = 1'b1;
    req_opcode  = op;
    req_address = {LINE_BASE | t_cl_address'(idx), off[1:0], 2'b00};
    req_data    = data;
    req_reg_id  = (op == RD_OP) ? next_reg : t_reg_id'(idx);
    while (!accepted) begin
        @(negedge clk);
        accepted = !stall;
        cancel   = lu_mb_hit_cancel;
        if (accepted && (op == WR_OP)) begin
            golden[idx][off*`TQ_WORD_W +: `TQ_WORD_W] = data;
        end else if (accepted) begin
            exp_reg.push_back(next_reg);
            exp_data.push_back(golden[idx][off*`TQ_WORD_W +: `TQ_WORD_W]);
            next_reg++;
        end
        @(posedge clk);
        #1;
    end
    req_valid = 1'b0;
endtask

// oldest outstanding read with this reg id
task automatic match_rsp();
    int k;
    k = -1;
    foreach (exp_reg[i]) begin
        if ((k < 0) && (exp_reg[i] == rsp_reg_id)) begin
            k = i;
        end
    end
    if (k < 0) begin
        $display("response for register %0d arrived with no read outstanding", rsp_reg_id);
        $display("STATUS: FAIL");
        $fatal(1, "unexpected response");
    end
    check_val("rsp_data", exp_data[k], rsp_data);
    exp_reg.delete(k);
    exp_data.delete(k);
endtask

task automatic wait_drained();
    logic done;
    done = 1'b0;
    while (!done) begin
        @(negedge clk);
        done = queue_drained();
        @(posedge clk);
        #1;
    end
endtask

`endif

// ==== verif/cache_tq_tb.sv ====
// testbench for the cache transaction queue
// random core traffic against pipe and far-memory models and a golden memory
`timescale 1ns/1ps
`include "cache_tq_macros.svh"

module cache_tq_tb
    import cache_tq_pkg::*;
();

    localparam int NUM_RAND   = 200;
    localparam int NUM_REQ    = NUM_RAND + 8;     // 8 directed requests
    localparam int MAX_CYCLES = 40 * NUM_REQ;
    localparam t_cl_address LINE_BASE = 16'h0a50; // low 3 bits pick one of 8 lines

    typedef struct packed {
        logic                  v;
        t_lu_op                op;
        logic [`TQ_ADDR_W-1:0] addr;
        t_word                 data;
        t_cl                   cl;
        t_tq_id                id;
    } t_lu_rec;

    logic clk, rst_n, req_valid, stall, rsp_valid;
    logic lu_valid, lu_mb_hit_cancel, lu_rsp_valid, fm_rsp_valid;
    logic [`TQ_ADDR_W-1:0] req_address, lu_address, lu_rsp_address;
    t_core_op   req_opcode;
    t_word      req_data, rsp_data, lu_data;
    t_reg_id    req_reg_id, rsp_reg_id;
    t_lu_op     lu_op, lu_rsp_op;
    t_lu_result lu_rsp_result;
    t_cl        lu_cl_data, lu_rsp_cl_data, fm_rsp_data;
    t_tq_id     lu_tq_id, lu_rsp_tq_id, fm_rsp_tq_id;

    integer      seed;
    int          cycles = 0;
    t_cl         golden [8];   // updated in acceptance order
    t_reg_id     exp_reg [$];
    t_word       exp_data [$];
    t_reg_id     next_reg;
    t_lu_rec     cap, st0, st1; // pipe delay line
    t_cl         pipe_store [8];
    logic [7:0]  pipe_present;
    logic [7:0]  line_open;    // missed, fill not answered yet
    logic [3:0]  fm_pend;
    int          fm_delay [4];
    t_cl_address fm_cl [4];

    `include "cache_tq_tb_tasks.svh"

    cache_tq i_cache_tq (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    // --------------------------------------------------
    // lookup and response monitor
    // --------------------------------------------------
    always @(negedge clk) begin
        int idx;
        int rsp_idx;
        idx     = lu_address[`TQ_LSB_CL_ADDR +: 3];
        rsp_idx = lu_rsp_address[`TQ_LSB_CL_ADDR +: 3];
        if (rst_n && lu_valid) begin
            if (!lu_mb_hit_cancel) begin
                cap = {1'b1, lu_op, lu_address, lu_data, lu_cl_data, lu_tq_id};
            end
            if (lu_op == FILL_LU) begin
                check_val("fill_line", golden[idx], lu_cl_data); // far-memory line plus writes
            end else begin
                check_val("mb_hit_cancel", line_open[idx], lu_mb_hit_cancel);
            end
        end
        if (rst_n && rsp_valid) begin
            match_rsp();
        end
        if (rst_n && lu_rsp_valid && (lu_rsp_result == MISS)) begin
            line_open[rsp_idx]     = 1'b1;
            fm_pend[lu_rsp_tq_id]  = 1'b1;
            fm_delay[lu_rsp_tq_id] = 1 + $unsigned($random(seed)) % 6;
            fm_cl[lu_rsp_tq_id]    = lu_rsp_address[`TQ_ADDR_W-1:`TQ_LSB_CL_ADDR];
        end else if (rst_n && lu_rsp_valid && (lu_rsp_result == FILL)) begin
            line_open[rsp_idx] = 1'b0;
        end
    end

    // --------------------------------------------------
    // pipe and far-memory models
    // --------------------------------------------------
    always @(posedge clk) begin
        int   idx;
        int   off;
        logic sent;
        #1;
        st1 = st0;
        st0 = cap;
        cap = '0;
        idx = st1.addr[`TQ_LSB_CL_ADDR +: 3];
        off = st1.addr[`TQ_MSB_WORD_OFFSET:`TQ_LSB_WORD_OFFSET];
        lu_rsp_valid   = st1.v;
        lu_rsp_op      = st1.op;
        lu_rsp_address = st1.addr;
        lu_rsp_tq_id   = st1.id;
        lu_rsp_result  = MISS;
        lu_rsp_cl_data = '0;
        if (st1.v && (st1.op == FILL_LU)) begin
            pipe_store[idx]   = st1.cl;
            pipe_present[idx] = 1'b1;
            lu_rsp_result     = FILL;
            lu_rsp_cl_data    = st1.cl;
        end else if (st1.v && pipe_present[idx]) begin
            if (st1.op == WR_LU) begin
                pipe_store[idx][off*`TQ_WORD_W +: `TQ_WORD_W] = st1.data;
            end
            lu_rsp_result  = HIT;
            lu_rsp_cl_data = pipe_store[idx];
        end
        fm_rsp_valid = 1'b0;
        sent         = 1'b0;
        for (int i = 0; i < 4; i++) begin // one fill per cycle, lowest id first
            if (fm_pend[i] && (fm_delay[i] > 0)) begin
                fm_delay[i]--;
            end
            if (fm_pend[i] && (fm_delay[i] == 0) && !sent) begin
                fm_rsp_valid = 1'b1;
                fm_rsp_tq_id = t_tq_id'(i);
                fm_rsp_data  = fm_line(fm_cl[i]);
                fm_pend[i]   = 1'b0;
                sent         = 1'b1;
            end
        end
    end

    initial begin
        logic     cancel;
        t_core_op op;
        int       gap;
        int       idx;
        int       off;
        t_word    data;
        seed = 32'h9d9b;
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_opcode = RD_OP;
        req_address = '0;
        req_data = '0;
        req_reg_id = '0;
        lu_rsp_valid = 1'b0;
        lu_rsp_op = NO_LU;
        lu_rsp_result = HIT;
        lu_rsp_address = '0;
        lu_rsp_cl_data = '0;
        lu_rsp_tq_id = '0;
        fm_rsp_valid = 1'b0;
        fm_rsp_tq_id = '0;
        fm_rsp_data = '0;
        cap = '0;
        st0 = '0;
        st1 = '0;
        pipe_present = '0;
        line_open = '0;
        fm_pend = '0;
        next_reg = '0;
        for (int i = 0; i < 8; i++) begin
            golden[i] = fm_line(LINE_BASE | t_cl_address'(i));
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_val("reset_stall", 1'b0, stall);
        check_val("reset_lu_valid", 1'b0, lu_valid);
        check_val("reset_rsp_valid", 1'b0, rsp_valid);
        @(posedge clk);
        #1;

        // four read misses fill the queue, the next request waits for a free entry
        for (int i = 0; i < 4; i++) begin
            send_req(RD_OP, i, i, '0, cancel);
        end
        @(negedge clk);
        check_val("stall_full", 1'b1, stall);
        @(posedge clk);
        #1;
        send_req(WR_OP, 5, 0, 32'h5555_0000, cancel);
        wait_drained();

        // write miss, then write after write and read after write on that line
        send_req(WR_OP, 4, 1, 32'h1111_aaaa, cancel);
        send_req(WR_OP, 4, 2, 32'h2222_bbbb, cancel);
        check_val("waw_cancel", 1'b1, cancel);
        send_req(RD_OP, 4, 1, '0, cancel);
        check_val("raw_cancel", 1'b1, cancel);

        // random traffic over the 8 lines
        repeat (NUM_RAND) begin
            gap = $unsigned($random(seed)) % 3;
            op = ($random(seed) & 1) ? WR_OP : RD_OP;
            idx = $unsigned($random(seed)) % 8;
            off = $unsigned($random(seed)) % 4;
            data = $random(seed);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send_req(op, idx, off, data, cancel);
        end
        wait_drained();

        if (exp_reg.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("%0d reads never got a response", exp_reg.size());
            $display("STATUS: FAIL");
            $fatal(1, "missing responses");
        end
    end

endmodule
